// File: logic/csr_settings.svh
/*
 widths, machine CSR addresses, misa word and identity words
 for the csr unit
*/
`ifndef CSR_SETTINGS_SVH
`define CSR_SETTINGS_SVH

`define CSR_XLEN   32
`define CSR_ADDR_W 12

// trap and status registers
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MTVAL     12'h343
`define CSR_ADDR_MIP       12'h344

// counters, low and high words
`define CSR_ADDR_MCYCLE    12'hb00
`define CSR_ADDR_MINSTRET  12'hb02
`define CSR_ADDR_MCYCLEH   12'hb80
`define CSR_ADDR_MINSTRETH 12'hb82
`define CSR_ADDR_TIME      12'hc01
`define CSR_ADDR_TIMEH     12'hc81

// identity registers, read only
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12
`define CSR_ADDR_MIMPID    12'hf13
`define CSR_ADDR_MHARTID   12'hf14

`define CSR_MISA_VALUE      32'h4000_1100 // mxl=1, i and m
`define CSR_MVENDORID_VALUE 32'h0000_0000
`define CSR_MARCHID_VALUE   32'h0000_0000
`define CSR_MIMPID_VALUE    32'h0000_0000
`define CSR_MHARTID_VALUE   32'h0000_0000

`define CSR_MSTATUS_MIE_BIT 3

`endif

// File: logic/csr_pkg.sv
/*
 csr unit types: register word, counter, address, register selection
*/
`include "csr_settings.svh"

package csr_pkg;

    typedef logic [`CSR_XLEN-1:0]   csr_word_t;
    typedef logic [2*`CSR_XLEN-1:0] csr_dword_t;
    typedef logic [`CSR_ADDR_W-1:0] csr_addr_t;

    // one value per known CSR, none for idle or unknown
    typedef enum logic [4:0] {
        CSR_SEL_NONE,
        CSR_SEL_MSTATUS, CSR_SEL_MISA, CSR_SEL_MIE, CSR_SEL_MTVEC,
        CSR_SEL_MSCRATCH, CSR_SEL_MEPC, CSR_SEL_MCAUSE, CSR_SEL_MTVAL,
        CSR_SEL_MIP,
        CSR_SEL_MCYCLE, CSR_SEL_MCYCLEH, CSR_SEL_MINSTRET, CSR_SEL_MINSTRETH,
        CSR_SEL_TIME, CSR_SEL_TIMEH,
        CSR_SEL_MVENDORID, CSR_SEL_MARCHID, CSR_SEL_MIMPID, CSR_SEL_MHARTID
    } csr_sel_e;

endpackage

// File: logic/csr_decode.sv
/*
 address decode for the ex and clint ports
 write selections are gated by the strobes
*/
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_decode (
    input  logic                ex_we_i,
    input  csr_pkg::csr_addr_t  ex_waddr_i,
    input  csr_pkg::csr_addr_t  ex_raddr_i,
    input  logic                clint_we_i,
    input  csr_pkg::csr_addr_t  clint_waddr_i,
    input  csr_pkg::csr_addr_t  clint_raddr_i,
    output csr_pkg::csr_sel_e   ex_wsel_o,
    output csr_pkg::csr_sel_e   clint_wsel_o,
    output csr_pkg::csr_sel_e   ex_rsel_o,
    output csr_pkg::csr_sel_e   clint_rsel_o
);

    // shared table for all four lookups
    function automatic csr_pkg::csr_sel_e addr_to_sel(input csr_pkg::csr_addr_t addr);
        case (addr)
            `CSR_ADDR_MSTATUS:   return csr_pkg::CSR_SEL_MSTATUS;
            `CSR_ADDR_MISA:      return csr_pkg::CSR_SEL_MISA;
            `CSR_ADDR_MIE:       return csr_pkg::CSR_SEL_MIE;
            `CSR_ADDR_MTVEC:     return csr_pkg::CSR_SEL_MTVEC;
            `CSR_ADDR_MSCRATCH:  return csr_pkg::CSR_SEL_MSCRATCH;
            `CSR_ADDR_MEPC:      return csr_pkg::CSR_SEL_MEPC;
            `CSR_ADDR_MCAUSE:    return csr_pkg::CSR_SEL_MCAUSE;
            `CSR_ADDR_MTVAL:     return csr_pkg::CSR_SEL_MTVAL;
            `CSR_ADDR_MIP:       return csr_pkg::CSR_SEL_MIP;
            `CSR_ADDR_MCYCLE:    return csr_pkg::CSR_SEL_MCYCLE;
            `CSR_ADDR_MCYCLEH:   return csr_pkg::CSR_SEL_MCYCLEH;
            `CSR_ADDR_MINSTRET:  return csr_pkg::CSR_SEL_MINSTRET;
            `CSR_ADDR_MINSTRETH: return csr_pkg::CSR_SEL_MINSTRETH;
            `CSR_ADDR_TIME:      return csr_pkg::CSR_SEL_TIME;
            `CSR_ADDR_TIMEH:     return csr_pkg::CSR_SEL_TIMEH;
            `CSR_ADDR_MVENDORID: return csr_pkg::CSR_SEL_MVENDORID;
            `CSR_ADDR_MARCHID:   return csr_pkg::CSR_SEL_MARCHID;
            `CSR_ADDR_MIMPID:    return csr_pkg::CSR_SEL_MIMPID;
            `CSR_ADDR_MHARTID:   return csr_pkg::CSR_SEL_MHARTID;
            default:             return csr_pkg::CSR_SEL_NONE; // unknown reads as zero
        endcase
    endfunction

    assign ex_wsel_o    = ex_we_i ? addr_to_sel(ex_waddr_i) : csr_pkg::CSR_SEL_NONE;
    assign clint_wsel_o = clint_we_i ? addr_to_sel(clint_waddr_i) : csr_pkg::CSR_SEL_NONE;

    assign ex_rsel_o    = addr_to_sel(ex_raddr_i);
    assign clint_rsel_o = addr_to_sel(clint_raddr_i);

endmodule

// File: logic/csr_trap_regs.sv
/*
 trap and status registers with ex-first write priority
 and the global interrupt enable
*/
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_trap_regs (
    input  logic                clk,
    input  logic                reset_i,
    input  csr_pkg::csr_sel_e   ex_wsel_i,
    input  csr_pkg::csr_sel_e   clint_wsel_i,
    input  csr_pkg::csr_word_t  ex_wdata_i,
    input  csr_pkg::csr_word_t  clint_wdata_i,
    output csr_pkg::csr_word_t  mtvec_o,
    output csr_pkg::csr_word_t  mcause_o,
    output csr_pkg::csr_word_t  mepc_o,
    output csr_pkg::csr_word_t  mie_o,
    output csr_pkg::csr_word_t  mstatus_o,
    output csr_pkg::csr_word_t  mscratch_o,
    output csr_pkg::csr_word_t  mip_o,
    output csr_pkg::csr_word_t  mtval_o,
    output logic                global_int_en_o
);

    // ex wins over clint, otherwise hold
    function automatic csr_pkg::csr_word_t next_word(input csr_pkg::csr_sel_e sel,
                                                     input csr_pkg::csr_word_t cur);
        if (ex_wsel_i == sel) begin
            return ex_wdata_i;
        end
        if (clint_wsel_i == sel) begin
            return clint_wdata_i;
        end
        return cur;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mtvec_o    <= '0;
            mcause_o   <= '0;
            mepc_o     <= '0;
            mie_o      <= '0;
            mstatus_o  <= '0;
            mscratch_o <= '0;
            mip_o      <= '0;
            mtval_o    <= '0;
        end else begin
            mtvec_o    <= next_word(csr_pkg::CSR_SEL_MTVEC, mtvec_o);
            mcause_o   <= next_word(csr_pkg::CSR_SEL_MCAUSE, mcause_o);
            mepc_o     <= next_word(csr_pkg::CSR_SEL_MEPC, mepc_o);
            mie_o      <= next_word(csr_pkg::CSR_SEL_MIE, mie_o);
            mstatus_o  <= next_word(csr_pkg::CSR_SEL_MSTATUS, mstatus_o);
            mscratch_o <= next_word(csr_pkg::CSR_SEL_MSCRATCH, mscratch_o);
            mip_o      <= next_word(csr_pkg::CSR_SEL_MIP, mip_o);
            mtval_o    <= next_word(csr_pkg::CSR_SEL_MTVAL, mtval_o);
        end
    end

    assign global_int_en_o = mstatus_o[`CSR_MSTATUS_MIE_BIT]; // mstatus.mie

    // reset wins over a same-cycle mstatus write
    assert property (@(posedge clk) reset_i |=> !global_int_en_o)
        else $error("interrupts enabled right after reset");

endmodule

// File: logic/csr_counters.sv
/*
 mcycle, minstret and time counters
 half-word writes with ex-first priority
 writes to time are ignored
*/
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_counters (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                inst_valid_i,
    input  csr_pkg::csr_sel_e   ex_wsel_i,
    input  csr_pkg::csr_sel_e   clint_wsel_i,
    input  csr_pkg::csr_word_t  ex_wdata_i,
    input  csr_pkg::csr_word_t  clint_wdata_i,
    output csr_pkg::csr_dword_t mcycle_o,
    output csr_pkg::csr_dword_t minstret_o,
    output csr_pkg::csr_dword_t time_o
);

    logic mcycle_wr; // either half of mcycle written this cycle

    // a write to either half replaces it and skips the increment
    function automatic csr_pkg::csr_dword_t next_count(input csr_pkg::csr_dword_t cur,
                                                       input csr_pkg::csr_sel_e lo_sel,
                                                       input csr_pkg::csr_sel_e hi_sel,
                                                       input logic inc);
        csr_pkg::csr_word_t lo;
        csr_pkg::csr_word_t hi;
        logic               written;
        lo      = cur[`CSR_XLEN-1:0];
        hi      = cur[2*`CSR_XLEN-1:`CSR_XLEN];
        written = 1'b1;
        if (ex_wsel_i == lo_sel) begin
            lo = ex_wdata_i;
        end else if (clint_wsel_i == lo_sel) begin
            lo = clint_wdata_i;
        end
        if (ex_wsel_i == hi_sel) begin
            hi = ex_wdata_i;
        end else if (clint_wsel_i == hi_sel) begin
            hi = clint_wdata_i;
        end else if (ex_wsel_i != lo_sel && clint_wsel_i != lo_sel) begin
            written = 1'b0; // neither half touched
        end
        if (written) begin
            return {hi, lo};
        end
        return cur + csr_pkg::csr_dword_t'(inc);
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mcycle_o   <= '0;
            minstret_o <= '0;
            time_o     <= '0;
        end else begin
            mcycle_o   <= next_count(mcycle_o, csr_pkg::CSR_SEL_MCYCLE,
                                     csr_pkg::CSR_SEL_MCYCLEH, 1'b1);
            minstret_o <= next_count(minstret_o, csr_pkg::CSR_SEL_MINSTRET,
                                     csr_pkg::CSR_SEL_MINSTRETH, inst_valid_i);
            time_o     <= time_o + 64'd1; // writes to time are dropped
        end
    end

    assign mcycle_wr = (ex_wsel_i == csr_pkg::CSR_SEL_MCYCLE)
                    || (ex_wsel_i == csr_pkg::CSR_SEL_MCYCLEH)
                    || (clint_wsel_i == csr_pkg::CSR_SEL_MCYCLE)
                    || (clint_wsel_i == csr_pkg::CSR_SEL_MCYCLEH);

    // mcycle and time count in step unless mcycle is written
    assert property (@(posedge clk) !reset_i && !mcycle_wr |=>
                     mcycle_o - time_o == $past(mcycle_o - time_o))
        else $error("mcycle and time drifted apart");

endmodule

// File: logic/csr_read_mux.sv
/*
 read data for the ex and clint ports
 same-cycle bypass, identity constants, zero for unknown
*/
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_read_mux (
    input  csr_pkg::csr_sel_e   ex_rsel_i,
    input  csr_pkg::csr_sel_e   clint_rsel_i,
    input  csr_pkg::csr_sel_e   ex_wsel_i,
    input  csr_pkg::csr_sel_e   clint_wsel_i,
    input  csr_pkg::csr_word_t  ex_wdata_i,
    input  csr_pkg::csr_word_t  clint_wdata_i,
    input  csr_pkg::csr_word_t  mtvec_i,
    input  csr_pkg::csr_word_t  mcause_i,
    input  csr_pkg::csr_word_t  mepc_i,
    input  csr_pkg::csr_word_t  mie_i,
    input  csr_pkg::csr_word_t  mstatus_i,
    input  csr_pkg::csr_word_t  mscratch_i,
    input  csr_pkg::csr_word_t  mip_i,
    input  csr_pkg::csr_word_t  mtval_i,
    input  csr_pkg::csr_dword_t mcycle_i,
    input  csr_pkg::csr_dword_t minstret_i,
    input  csr_pkg::csr_dword_t time_i,
    output csr_pkg::csr_word_t  ex_rdata_o,
    output csr_pkg::csr_word_t  clint_rdata_o
);

    function automatic csr_pkg::csr_word_t reg_word(input csr_pkg::csr_sel_e sel);
        case (sel)
            csr_pkg::CSR_SEL_MSTATUS:   return mstatus_i;
            csr_pkg::CSR_SEL_MIE:       return mie_i;
            csr_pkg::CSR_SEL_MTVEC:     return mtvec_i;
            csr_pkg::CSR_SEL_MSCRATCH:  return mscratch_i;
            csr_pkg::CSR_SEL_MEPC:      return mepc_i;
            csr_pkg::CSR_SEL_MCAUSE:    return mcause_i;
            csr_pkg::CSR_SEL_MTVAL:     return mtval_i;
            csr_pkg::CSR_SEL_MIP:       return mip_i;
            csr_pkg::CSR_SEL_MCYCLE:    return mcycle_i[`CSR_XLEN-1:0];
            csr_pkg::CSR_SEL_MCYCLEH:   return mcycle_i[2*`CSR_XLEN-1:`CSR_XLEN];
            csr_pkg::CSR_SEL_MINSTRET:  return minstret_i[`CSR_XLEN-1:0];
            csr_pkg::CSR_SEL_MINSTRETH: return minstret_i[2*`CSR_XLEN-1:`CSR_XLEN];
            csr_pkg::CSR_SEL_TIME:      return time_i[`CSR_XLEN-1:0];
            csr_pkg::CSR_SEL_TIMEH:     return time_i[2*`CSR_XLEN-1:`CSR_XLEN];
            csr_pkg::CSR_SEL_MISA:      return `CSR_MISA_VALUE;
            csr_pkg::CSR_SEL_MVENDORID: return `CSR_MVENDORID_VALUE;
            csr_pkg::CSR_SEL_MARCHID:   return `CSR_MARCHID_VALUE;
            csr_pkg::CSR_SEL_MIMPID:    return `CSR_MIMPID_VALUE;
            csr_pkg::CSR_SEL_MHARTID:   return `CSR_MHARTID_VALUE;
            default:                    return '0;
        endcase
    endfunction

    // own write data wins when the port hits its own known target
    function automatic csr_pkg::csr_word_t port_word(input csr_pkg::csr_sel_e rsel,
                                                     input csr_pkg::csr_sel_e wsel,
                                                     input csr_pkg::csr_word_t wdata);
        if (wsel != csr_pkg::CSR_SEL_NONE && wsel == rsel) begin
            return wdata;
        end
        return reg_word(rsel);
    endfunction

    always_comb begin
        ex_rdata_o    = port_word(ex_rsel_i, ex_wsel_i, ex_wdata_i);
        clint_rdata_o = port_word(clint_rsel_i, clint_wsel_i, clint_wdata_i);
    end

endmodule

// File: logic/csr_unit.sv
/*
 machine-mode CSR unit, top level
 decode, trap registers, counters and read mux
*/
`timescale 1ns/1ps

module csr_unit (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               inst_valid_i,
    input  logic               ex_we_i,
    input  csr_pkg::csr_addr_t ex_waddr_i,
    input  csr_pkg::csr_addr_t ex_raddr_i,
    input  csr_pkg::csr_word_t ex_wdata_i,
    output csr_pkg::csr_word_t ex_rdata_o,
    input  logic               clint_we_i,
    input  csr_pkg::csr_addr_t clint_waddr_i,
    input  csr_pkg::csr_addr_t clint_raddr_i,
    input  csr_pkg::csr_word_t clint_wdata_i,
    output csr_pkg::csr_word_t clint_rdata_o,
    output logic               global_int_en_o,
    output csr_pkg::csr_word_t clint_mtvec_o,
    output csr_pkg::csr_word_t clint_mepc_o,
    output csr_pkg::csr_word_t clint_mstatus_o,
    output csr_pkg::csr_word_t clint_mie_o
);

    csr_pkg::csr_sel_e   ex_wsel, clint_wsel, ex_rsel, clint_rsel;
    csr_pkg::csr_word_t  mtvec, mcause, mepc, mie, mstatus, mscratch, mip, mtval;
    csr_pkg::csr_dword_t mcycle, minstret, time_val;

    csr_decode csr_decode_i (
        .ex_we_i(ex_we_i), .ex_waddr_i(ex_waddr_i), .ex_raddr_i(ex_raddr_i),
        .clint_we_i(clint_we_i), .clint_waddr_i(clint_waddr_i),
        .clint_raddr_i(clint_raddr_i),
        .ex_wsel_o(ex_wsel), .clint_wsel_o(clint_wsel),
        .ex_rsel_o(ex_rsel), .clint_rsel_o(clint_rsel)
    );

    csr_trap_regs csr_trap_regs_i (
        .clk(clk), .reset_i(reset_i),
        .ex_wsel_i(ex_wsel), .clint_wsel_i(clint_wsel),
        .ex_wdata_i(ex_wdata_i), .clint_wdata_i(clint_wdata_i),
        .mtvec_o(mtvec), .mcause_o(mcause), .mepc_o(mepc), .mie_o(mie),
        .mstatus_o(mstatus), .mscratch_o(mscratch), .mip_o(mip), .mtval_o(mtval),
        .global_int_en_o(global_int_en_o)
    );

    csr_counters csr_counters_i (
        .clk(clk), .reset_i(reset_i), .inst_valid_i(inst_valid_i),
        .ex_wsel_i(ex_wsel), .clint_wsel_i(clint_wsel),
        .ex_wdata_i(ex_wdata_i), .clint_wdata_i(clint_wdata_i),
        .mcycle_o(mcycle), .minstret_o(minstret), .time_o(time_val)
    );

    csr_read_mux csr_read_mux_i (
        .ex_rsel_i(ex_rsel), .clint_rsel_i(clint_rsel),
        .ex_wsel_i(ex_wsel), .clint_wsel_i(clint_wsel),
        .ex_wdata_i(ex_wdata_i), .clint_wdata_i(clint_wdata_i),
        .mtvec_i(mtvec), .mcause_i(mcause), .mepc_i(mepc), .mie_i(mie),
        .mstatus_i(mstatus), .mscratch_i(mscratch), .mip_i(mip), .mtval_i(mtval),
        .mcycle_i(mcycle), .minstret_i(minstret), .time_i(time_val),
        .ex_rdata_o(ex_rdata_o), .clint_rdata_o(clint_rdata_o)
    );

    // trap state seen by the interrupt controller
    assign clint_mtvec_o   = mtvec;
    assign clint_mepc_o    = mepc;
    assign clint_mstatus_o = mstatus;
    assign clint_mie_o     = mie;

endmodule

// File: bench/csr_unit_tb.sv
/*
 testbench for the csr unit: clock, reset, LCG,
 stimulus table with expected reads, row loop and checks
*/
`timescale 1ns/1ps
`include "csr_settings.svh"

module csr_unit_tb;

    localparam int CLK_PERIOD = 8;
    localparam int EX    = 0;
    localparam int CLINT = 1;
    localparam int BOTH  = 2; // clint writes the inverted word
    localparam csr_pkg::csr_addr_t UNKNOWN = 12'h7c0;

    // row mode bits
    localparam int W_RAND   = 1;  // write data from the LCG
    localparam int E_LAST   = 2;  // expect last random word
    localparam int E_DELTA  = 4;  // expect captured value plus expv
    localparam int CAPTURE  = 8;
    localparam int IV       = 16; // inst_valid_i high this cycle
    localparam int X_EXPORT = 32;
    localparam int X_GIE    = 64;

    typedef struct packed {
        int                 test;
        int                 port;
        logic               we;
        csr_pkg::csr_addr_t waddr;
        csr_pkg::csr_word_t wdata;
        csr_pkg::csr_addr_t raddr;
        csr_pkg::csr_word_t expv;
        int                 mode;
    } row_t;

    logic               clk;
    logic               reset_i;
    logic               inst_valid_i;
    logic               ex_we_i;
    csr_pkg::csr_addr_t ex_waddr_i;
    csr_pkg::csr_addr_t ex_raddr_i;
    csr_pkg::csr_word_t ex_wdata_i;
    csr_pkg::csr_word_t ex_rdata_o;
    logic               clint_we_i;
    csr_pkg::csr_addr_t clint_waddr_i;
    csr_pkg::csr_addr_t clint_raddr_i;
    csr_pkg::csr_word_t clint_wdata_i;
    csr_pkg::csr_word_t clint_rdata_o;
    logic               global_int_en_o;
    csr_pkg::csr_word_t clint_mtvec_o;
    csr_pkg::csr_word_t clint_mepc_o;
    csr_pkg::csr_word_t clint_mstatus_o;
    csr_pkg::csr_word_t clint_mie_o;

    row_t               rows[$];
    csr_pkg::csr_word_t lcg_state;
    int                 checks;
    int                 errors;
    logic               timed_out;
    string              titles [1:5] = '{"reset values", "write and read back",
                                         "bypass and priority", "interrupt enable", "counters"};

    csr_unit csr_unit_i (
        .clk(clk), .reset_i(reset_i), .inst_valid_i(inst_valid_i),
        .ex_we_i(ex_we_i), .ex_waddr_i(ex_waddr_i), .ex_raddr_i(ex_raddr_i),
        .ex_wdata_i(ex_wdata_i), .ex_rdata_o(ex_rdata_o),
        .clint_we_i(clint_we_i), .clint_waddr_i(clint_waddr_i),
        .clint_raddr_i(clint_raddr_i), .clint_wdata_i(clint_wdata_i),
        .clint_rdata_o(clint_rdata_o), .global_int_en_o(global_int_en_o),
        .clint_mtvec_o(clint_mtvec_o), .clint_mepc_o(clint_mepc_o),
        .clint_mstatus_o(clint_mstatus_o), .clint_mie_o(clint_mie_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic csr_pkg::csr_word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic add_row(input int test, input int port, input logic we,
                           input csr_pkg::csr_addr_t waddr, input csr_pkg::csr_word_t wdata,
                           input csr_pkg::csr_addr_t raddr, input csr_pkg::csr_word_t expv,
                           input int mode);
        rows.push_back('{test, port, we, waddr, wdata, raddr, expv, mode});
    endtask

    task automatic build_table();
        csr_pkg::csr_addr_t trap_addrs [8];
        int                 i;
        trap_addrs = '{`CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
                       `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MTVAL, `CSR_ADDR_MIP};
        for (i = 0; i < 8; i++) begin
            add_row(1, EX, 0, 0, 0, trap_addrs[i], 0, X_EXPORT | X_GIE);
        end
        add_row(1, EX, 0, 0, 0, `CSR_ADDR_MISA, `CSR_MISA_VALUE, 0);
        add_row(1, EX, 0, 0, 0, UNKNOWN, 0, 0);
        // each trap register, alternating ports, bypass then read back
        for (i = 0; i < 8; i++) begin
            add_row(2, i % 2, 1, trap_addrs[i], 0, trap_addrs[i], 0, W_RAND | E_LAST);
            add_row(2, EX, 0, 0, 0, trap_addrs[i], 0, E_LAST | X_EXPORT);
        end
        add_row(2, EX, 1, `CSR_ADDR_MISA, 0, UNKNOWN, 0, W_RAND);
        add_row(2, EX, 0, 0, 0, `CSR_ADDR_MISA, `CSR_MISA_VALUE, 0);
        add_row(2, CLINT, 1, `CSR_ADDR_MHARTID, 0, UNKNOWN, 0, W_RAND);
        add_row(2, EX, 0, 0, 0, `CSR_ADDR_MHARTID, `CSR_MHARTID_VALUE, 0);
        add_row(2, EX, 0, 0, 0, `CSR_ADDR_TIME, 0, CAPTURE);
        add_row(2, CLINT, 1, `CSR_ADDR_TIME, 0, UNKNOWN, 0, W_RAND);
        add_row(2, EX, 0, 0, 0, `CSR_ADDR_TIME, 2, E_DELTA);
        add_row(3, EX, 1, `CSR_ADDR_MSCRATCH, 32'h1357_9bdf, `CSR_ADDR_MSCRATCH,
                32'h1357_9bdf, 0);
        add_row(3, CLINT, 1, `CSR_ADDR_MEPC, 0, `CSR_ADDR_MEPC, 0, W_RAND | E_LAST);
        add_row(3, BOTH, 1, `CSR_ADDR_MTVAL, 0, `CSR_ADDR_MTVAL, 0, W_RAND | E_LAST);
        add_row(3, EX, 0, 0, 0, `CSR_ADDR_MTVAL, 0, E_LAST); // ex value survives
        add_row(3, EX, 1, UNKNOWN, 32'hdead_beef, UNKNOWN, 0, 0);
        add_row(4, EX, 1, `CSR_ADDR_MSTATUS, 32'h0000_1808, UNKNOWN, 0, 0);
        add_row(4, EX, 0, 0, 0, `CSR_ADDR_MSTATUS, 32'h0000_1808, X_GIE | X_EXPORT);
        add_row(4, CLINT, 1, `CSR_ADDR_MSTATUS, 32'h0000_0080, UNKNOWN, 0, 0);
        add_row(4, EX, 0, 0, 0, `CSR_ADDR_MSTATUS, 32'h0000_0080, X_GIE | X_EXPORT);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_TIME, 0, CAPTURE);
        add_row(5, EX, 1, `CSR_ADDR_MCYCLE, 32'h0000_1000, `CSR_ADDR_MCYCLE,
                32'h0000_1000, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MCYCLE, 32'h0000_1000, 0);
        add_row(5, EX, 0, 0, 0, UNKNOWN, 0, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MCYCLE, 32'h0000_1002, 0); // two edges later
        add_row(5, CLINT, 1, `CSR_ADDR_MCYCLEH, 32'h0000_00a5, UNKNOWN, 0, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MCYCLEH, 32'h0000_00a5, 0);
        add_row(5, EX, 1, `CSR_ADDR_MINSTRET, 32'h0000_0040, UNKNOWN, 0, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MINSTRET, 32'h0000_0040, IV);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MINSTRET, 32'h0000_0041, IV);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MINSTRET, 32'h0000_0042, IV);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MINSTRET, 32'h0000_0043, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_MINSTRET, 32'h0000_0043, 0);
        add_row(5, EX, 0, 0, 0, `CSR_ADDR_TIME, 13, E_DELTA); // 13 rows after capture
    endtask

    task automatic drive_row(input row_t row, input csr_pkg::csr_word_t wdata);
        ex_we_i       = row.we && row.port != CLINT;
        clint_we_i    = row.we && row.port != EX;
        ex_waddr_i    = row.waddr;
        clint_waddr_i = row.waddr;
        ex_wdata_i    = wdata;
        clint_wdata_i = (row.port == BOTH) ? ~wdata : wdata;
        ex_raddr_i    = row.raddr;
        clint_raddr_i = row.raddr;
        inst_valid_i  = (row.mode & IV) != 0;
    endtask

    task automatic compare_word(input string what, input csr_pkg::csr_word_t got,
                                input csr_pkg::csr_word_t want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic compare_export(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_word_t want);
        case (addr)
            `CSR_ADDR_MTVEC:   compare_word("clint_mtvec_o", clint_mtvec_o, want);
            `CSR_ADDR_MEPC:    compare_word("clint_mepc_o", clint_mepc_o, want);
            `CSR_ADDR_MSTATUS: compare_word("clint_mstatus_o", clint_mstatus_o, want);
            `CSR_ADDR_MIE:     compare_word("clint_mie_o", clint_mie_o, want);
            default: ;         // not exported
        endcase
    endtask

    task automatic wait_edges(input int n);
        int  seen;
        time start;
        seen  = 0;
        start = $time;
        while (seen < n && !timed_out) begin
            @(posedge clk);
            seen++;
            if ($time - start > (n + 1) * CLK_PERIOD) begin
                timed_out = 1'b1;
                $display("timeout: %0d clock edges did not arrive in time", n);
            end
        end
    endtask

    initial begin
        int                 r;
        int                 start_checks;
        int                 start_errors;
        row_t               row;
        csr_pkg::csr_word_t wdata;
        csr_pkg::csr_word_t want;
        csr_pkg::csr_word_t base;
        csr_pkg::csr_word_t last_w;
        clk           = 1'b0;
        reset_i       = 1'b1;
        inst_valid_i  = 1'b0;
        ex_we_i       = 1'b0;
        ex_waddr_i    = '0;
        ex_raddr_i    = '0;
        ex_wdata_i    = '0;
        clint_we_i    = 1'b0;
        clint_waddr_i = '0;
        clint_raddr_i = '0;
        clint_wdata_i = '0;
        lcg_state     = 32'h63f69bb1;
        checks        = 0;
        errors        = 0;
        timed_out     = 1'b0;
        base          = '0;
        last_w        = '0;
        start_checks  = 0;
        start_errors  = 0;
        build_table();
        wait_edges(3);
        #1;
        reset_i = 1'b0;
        for (r = 0; r < rows.size() && !timed_out; r++) begin
            row   = rows[r];
            wdata = row.wdata;
            if ((row.mode & W_RAND) != 0) begin
                wdata  = lcg_next();
                last_w = wdata;
            end
            want = row.expv;
            if ((row.mode & E_LAST) != 0) begin
                want = last_w;
            end
            if ((row.mode & E_DELTA) != 0) begin
                want = base + row.expv;
            end
            drive_row(row, wdata);
            #(CLK_PERIOD - 2); // 1 ns before the next edge
            if ((row.mode & CAPTURE) != 0) begin
                base = ex_rdata_o;
            end else begin
                if (!row.we || row.port != CLINT) begin
                    compare_word($sformatf("ex read of %h", row.raddr), ex_rdata_o, want);
                end
                if (!row.we || row.port == CLINT) begin
                    compare_word($sformatf("clint read of %h", row.raddr), clint_rdata_o, want);
                end
                if ((row.mode & X_EXPORT) != 0) begin
                    compare_export(row.raddr, want);
                end
                if ((row.mode & X_GIE) != 0) begin
                    compare_word("global_int_en_o", {31'b0, global_int_en_o}, {31'b0, want[3]});
                end
            end
            if (r == rows.size() - 1 || rows[r + 1].test != row.test) begin
                $display("test %0d (%s) finished: %0d checks, %0d errors", row.test,
                         titles[row.test], checks - start_checks, errors - start_errors);
                start_checks = checks;
                start_errors = errors;
            end
            wait_edges(1);
            #1;
        end
        $display("all tests: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: csr_unit.f
+incdir+logic
logic/csr_pkg.sv
logic/csr_decode.sv
logic/csr_trap_regs.sv
logic/csr_counters.sv
logic/csr_read_mux.sv
logic/csr_unit.sv
bench/csr_unit_tb.sv

// File: Makefile
# Verilator simulation of the csr unit testbench

VERILATOR ?= verilator
FILELIST  ?= csr_unit.f
TOP       ?= csr_unit_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
